/* common/rv_id_pkg.sv */
`default_nettype none

package rv_id_pkg;

    localparam int XLEN      = 64;
    localparam int ILEN      = 32;
    localparam int REG_IDX_W = 5;

    // major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        OP_IMM    = 5'b00100,
        AUIPC     = 5'b00101,
        OP_IMM_32 = 5'b00110,
        STORE     = 5'b01000,
        OP_REG    = 5'b01100,
        LUI       = 5'b01101,
        OP_REG_32 = 5'b01110,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_PRIV    = 3'b000; // ecall / ebreak / mret
    localparam logic [2:0] F3_FENCE_I = 3'b001;

    typedef enum logic [4:0] {
        ALU_ADD_64, ALU_SUB_64, ALU_SLL_64, ALU_SRL_64, ALU_SRA_64,
        ALU_ADD_32, ALU_SUB_32, ALU_SLL_32, ALU_SRL_32, ALU_SRA_32,
        ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SRC2    // operand 2 straight through
    } alu_op_e;

    typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR, SRC2_ZERO} src2_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J,
        IMM_ZI      // csr immediate, zero-extended rs1 field
    } imm_fmt_e;

    typedef logic [2:0] div_sel_t;     // funct3 of mul/div
    localparam div_sel_t DIV_MUL = 3'b000;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic                 en;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      data;
    } wb_req_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rs1_idx;
        logic [REG_IDX_W-1:0] rs2_idx;
        logic [REG_IDX_W-1:0] rd_idx;
        alu_op_e              alu_op;
        src1_sel_e            src1_sel;
        src2_sel_e            src2_sel;
        imm_fmt_e             imm_fmt;
        logic                 is_jal;
        logic                 is_jalr;
        logic                 is_brc;
        logic                 wb_en;
        logic                 div_en;
        div_sel_t             div_sel;
        logic                 trap;
        logic                 trap_in;   // ecall
        logic                 trap_out;  // mret
        logic                 fence_i;
    } id_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        id_ctrl_t        ctrl;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
    } id_ex_t;

endpackage

`default_nettype wire

/* decode/id_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module id_decoder (
    input  wire logic [rv_id_pkg::ILEN-1:0] instr_i,
    output rv_id_pkg::id_ctrl_t             ctrl_o
);

    rv_id_pkg::opcode_e opcode;
    logic [2:0]         funct3;
    logic               f7_alt;    // sub / sra
    logic               f7_muldiv;
    logic               is_32;     // *W forms

    assign opcode    = rv_id_pkg::opcode_e'(instr_i[6:2]);
    assign funct3    = instr_i[14:12];
    assign f7_alt    = instr_i[30];
    assign f7_muldiv = instr_i[25];
    assign is_32     = instr_i[3];

    // shared by register and immediate arithmetic
    function automatic rv_id_pkg::alu_op_e arith_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       w32
    );
        rv_id_pkg::alu_op_e op;
        case (f3)
            rv_id_pkg::F3_ADD_SUB: begin
                if (alt) op = w32 ? rv_id_pkg::ALU_SUB_32 : rv_id_pkg::ALU_SUB_64;
                else     op = w32 ? rv_id_pkg::ALU_ADD_32 : rv_id_pkg::ALU_ADD_64;
            end
            rv_id_pkg::F3_SLL:  op = w32 ? rv_id_pkg::ALU_SLL_32 : rv_id_pkg::ALU_SLL_64;
            rv_id_pkg::F3_SLT:  op = rv_id_pkg::ALU_SLT;
            rv_id_pkg::F3_SLTU: op = rv_id_pkg::ALU_SLTU;
            rv_id_pkg::F3_XOR:  op = rv_id_pkg::ALU_XOR;
            rv_id_pkg::F3_SR: begin
                if (alt) op = w32 ? rv_id_pkg::ALU_SRA_32 : rv_id_pkg::ALU_SRA_64;
                else     op = w32 ? rv_id_pkg::ALU_SRL_32 : rv_id_pkg::ALU_SRL_64;
            end
            rv_id_pkg::F3_OR:   op = rv_id_pkg::ALU_OR;
            default:            op = rv_id_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.rd_idx   = instr_i[11:7];
        ctrl_o.alu_op   = rv_id_pkg::ALU_ADD_64;
        ctrl_o.src1_sel = rv_id_pkg::SRC1_RS1;
        ctrl_o.src2_sel = rv_id_pkg::SRC2_RS2;
        ctrl_o.imm_fmt  = rv_id_pkg::IMM_NONE;
        ctrl_o.div_sel  = rv_id_pkg::DIV_MUL;

        case (opcode)
            rv_id_pkg::OP_REG, rv_id_pkg::OP_REG_32: begin
                ctrl_o.rs1_idx = instr_i[19:15];
                ctrl_o.rs2_idx = instr_i[24:20];
                ctrl_o.wb_en   = 1'b1;
                ctrl_o.alu_op  = arith_op(funct3, f7_alt, is_32);
                ctrl_o.div_en  = f7_muldiv;
                ctrl_o.div_sel = funct3;
            end
            rv_id_pkg::OP_IMM, rv_id_pkg::OP_IMM_32: begin
                ctrl_o.rs1_idx  = instr_i[19:15];
                ctrl_o.src2_sel = rv_id_pkg::SRC2_IMM;
                ctrl_o.imm_fmt  = rv_id_pkg::IMM_I;
                ctrl_o.wb_en    = 1'b1;
                // no subi, bit 30 is part of the immediate here
                ctrl_o.alu_op   = arith_op(funct3, f7_alt && funct3 == rv_id_pkg::F3_SR, is_32);
            end
            rv_id_pkg::LOAD, rv_id_pkg::STORE: begin
                ctrl_o.rs1_idx  = instr_i[19:15];
                ctrl_o.src2_sel = rv_id_pkg::SRC2_IMM;
                if (opcode == rv_id_pkg::STORE) begin
                    ctrl_o.rs2_idx = instr_i[24:20];
                    ctrl_o.imm_fmt = rv_id_pkg::IMM_S;
                end else begin
                    ctrl_o.imm_fmt = rv_id_pkg::IMM_I;
                    ctrl_o.wb_en   = 1'b1;
                end
            end
            rv_id_pkg::BRANCH: begin
                ctrl_o.rs1_idx = instr_i[19:15];
                ctrl_o.rs2_idx = instr_i[24:20];
                ctrl_o.imm_fmt = rv_id_pkg::IMM_B;
                ctrl_o.is_brc  = 1'b1;
            end
            rv_id_pkg::JAL, rv_id_pkg::JALR: begin  // link value pc+4
                ctrl_o.src1_sel = rv_id_pkg::SRC1_PC;
                ctrl_o.src2_sel = rv_id_pkg::SRC2_FOUR;
                ctrl_o.wb_en    = 1'b1;
                if (opcode == rv_id_pkg::JALR) begin
                    ctrl_o.rs1_idx = instr_i[19:15];
                    ctrl_o.imm_fmt = rv_id_pkg::IMM_I;
                    ctrl_o.is_jalr = 1'b1;
                end else begin
                    ctrl_o.imm_fmt = rv_id_pkg::IMM_J;
                    ctrl_o.is_jal  = 1'b1;
                end
            end
            rv_id_pkg::LUI: begin
                ctrl_o.src2_sel = rv_id_pkg::SRC2_IMM;
                ctrl_o.imm_fmt  = rv_id_pkg::IMM_U;
                ctrl_o.alu_op   = rv_id_pkg::ALU_SRC2;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_id_pkg::AUIPC: begin
                ctrl_o.src1_sel = rv_id_pkg::SRC1_PC;
                ctrl_o.src2_sel = rv_id_pkg::SRC2_IMM;
                ctrl_o.imm_fmt  = rv_id_pkg::IMM_U;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_id_pkg::SYSTEM: begin
                ctrl_o.src2_sel = rv_id_pkg::SRC2_ZERO;
                if (funct3 == rv_id_pkg::F3_PRIV) begin
                    ctrl_o.trap = 1'b1;
                    if (!instr_i[20]) begin     // ebreak stays a bare trap
                        ctrl_o.trap_in  = ~instr_i[21];
                        ctrl_o.trap_out = instr_i[21];
                    end
                end else if (funct3[2]) begin   // csrr*i
                    ctrl_o.src2_sel = rv_id_pkg::SRC2_IMM;
                    ctrl_o.imm_fmt  = rv_id_pkg::IMM_ZI;
                    ctrl_o.alu_op   = rv_id_pkg::ALU_SRC2;
                    ctrl_o.wb_en    = 1'b1;
                end else begin
                    ctrl_o.rs1_idx = instr_i[19:15];
                    ctrl_o.wb_en   = 1'b1;
                end
            end
            rv_id_pkg::FENCE: begin
                ctrl_o.fence_i = (funct3 == rv_id_pkg::F3_FENCE_I);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input  wire logic [rv_id_pkg::ILEN-1:0] instr_i,
    input  rv_id_pkg::imm_fmt_e             fmt_i,
    output logic [rv_id_pkg::XLEN-1:0]      imm_o
);

    logic sgn;

    assign sgn = instr_i[31];

    always_comb begin
        case (fmt_i)
            rv_id_pkg::IMM_I: imm_o = {{52{sgn}}, instr_i[31:20]};
            rv_id_pkg::IMM_S: imm_o = {{52{sgn}}, instr_i[31:25], instr_i[11:7]};
            rv_id_pkg::IMM_B: begin
                imm_o = {{51{sgn}}, sgn, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            rv_id_pkg::IMM_U: imm_o = {{32{sgn}}, instr_i[31:12], 12'b0};
            rv_id_pkg::IMM_J: begin
                imm_o = {{43{sgn}}, sgn, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            rv_id_pkg::IMM_ZI: imm_o = {59'b0, instr_i[19:15]}; // uimm in rs1 slot
            default:           imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* dv/id_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage_tb;

    localparam int unsigned ID_CREDITS = 2;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   fetch_valid_i;
    rv_id_pkg::fetch_pkt_t  fetch_pkt_i;
    logic                   fetch_ready_o;
    rv_id_pkg::wb_req_t     wb_req_i;
    logic                   ex_valid_o;
    rv_id_pkg::id_ex_t      ex_bundle_o;
    logic                   ex_credit_i;

    integer                 seed = 32'h91b0fc7d;
    logic [63:0]            shadow [0:31];
    rv_id_pkg::id_ex_t      exp_q [$];
    int                     due_q [$];   // cycle each pending credit goes back
    int                     cyc, errors, checks, tests, recv_cnt, err_mark;
    logic                   credits_on;
    string                  cur_test;

    id_stage_top #(.ID_CREDITS(ID_CREDITS)) u_id_stage_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic rv_id_pkg::alu_op_e ref_alu(input logic [2:0] f3, input logic alt,
                                                   input logic w);
        rv_id_pkg::alu_op_e op;
        case (f3)
            3'd0: op = alt ? (w ? rv_id_pkg::ALU_SUB_32 : rv_id_pkg::ALU_SUB_64)
                           : (w ? rv_id_pkg::ALU_ADD_32 : rv_id_pkg::ALU_ADD_64);
            3'd1: op = w ? rv_id_pkg::ALU_SLL_32 : rv_id_pkg::ALU_SLL_64;
            3'd2: op = rv_id_pkg::ALU_SLT;
            3'd3: op = rv_id_pkg::ALU_SLTU;
            3'd4: op = rv_id_pkg::ALU_XOR;
            3'd5: op = alt ? (w ? rv_id_pkg::ALU_SRA_32 : rv_id_pkg::ALU_SRA_64)
                           : (w ? rv_id_pkg::ALU_SRL_32 : rv_id_pkg::ALU_SRL_64);
            3'd6: op = rv_id_pkg::ALU_OR;
            default: op = rv_id_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // expected control word, straight from the RV64I field rules
    function automatic rv_id_pkg::id_ctrl_t ref_ctrl(input logic [31:0] ins);
        rv_id_pkg::id_ctrl_t c;
        logic [2:0]          f3;
        c = '0;
        f3 = ins[14:12];
        c.rd_idx = ins[11:7];
        case (ins[6:2])
            5'b01100, 5'b01110: begin
                c.rs1_idx = ins[19:15];
                c.rs2_idx = ins[24:20];
                c.wb_en = 1'b1;
                c.alu_op = ref_alu(f3, ins[30], ins[3]);
                c.div_en = ins[25];
                c.div_sel = f3;
            end
            5'b00100, 5'b00110: begin
                c.rs1_idx = ins[19:15];
                c.src2_sel = rv_id_pkg::SRC2_IMM;
                c.imm_fmt = rv_id_pkg::IMM_I;
                c.wb_en = 1'b1;
                c.alu_op = ref_alu(f3, ins[30] && f3 == 3'd5, ins[3]);
            end
            5'b00000, 5'b01000: begin   // load, store
                c.rs1_idx = ins[19:15];
                c.src2_sel = rv_id_pkg::SRC2_IMM;
                c.wb_en = !ins[5];
                c.rs2_idx = ins[5] ? ins[24:20] : 5'd0;
                c.imm_fmt = ins[5] ? rv_id_pkg::IMM_S : rv_id_pkg::IMM_I;
            end
            5'b11000: begin
                c.rs1_idx = ins[19:15];
                c.rs2_idx = ins[24:20];
                c.imm_fmt = rv_id_pkg::IMM_B;
                c.is_brc = 1'b1;
            end
            5'b11011, 5'b11001: begin  // jal, jalr
                c.src1_sel = rv_id_pkg::SRC1_PC;
                c.src2_sel = rv_id_pkg::SRC2_FOUR;
                c.wb_en = 1'b1;
                c.is_jal = ins[3];
                c.is_jalr = !ins[3];
                c.rs1_idx = ins[3] ? 5'd0 : ins[19:15];
                c.imm_fmt = ins[3] ? rv_id_pkg::IMM_J : rv_id_pkg::IMM_I;
            end
            5'b01101, 5'b00101: begin  // lui, auipc
                c.src1_sel = ins[5] ? rv_id_pkg::SRC1_RS1 : rv_id_pkg::SRC1_PC;
                c.src2_sel = rv_id_pkg::SRC2_IMM;
                c.imm_fmt = rv_id_pkg::IMM_U;
                c.alu_op = ins[5] ? rv_id_pkg::ALU_SRC2 : rv_id_pkg::ALU_ADD_64;
                c.wb_en = 1'b1;
            end
            5'b11100: begin
                c.src2_sel = rv_id_pkg::SRC2_ZERO;
                if (f3 == 3'd0) begin
                    c.trap = 1'b1;
                    c.trap_in = (ins[21:20] == 2'b00);
                    c.trap_out = (ins[21:20] == 2'b10);
                end else begin
                    c.wb_en = 1'b1;
                    if (f3[2]) begin
                        c.src2_sel = rv_id_pkg::SRC2_IMM;
                        c.imm_fmt = rv_id_pkg::IMM_ZI;
                        c.alu_op = rv_id_pkg::ALU_SRC2;
                    end else begin
                        c.rs1_idx = ins[19:15];
                    end
                end
            end
            5'b00011: c.fence_i = (f3 == 3'd1);
            default: ;
        endcase
        return c;
    endfunction

    function automatic logic [63:0] ref_imm(input logic [31:0] ins, input rv_id_pkg::imm_fmt_e f);
        logic [63:0] s;
        s = {64{ins[31]}};
        case (f)
            rv_id_pkg::IMM_I:  return {s[63:12], ins[31:20]};
            rv_id_pkg::IMM_S:  return {s[63:12], ins[31:25], ins[11:7]};
            rv_id_pkg::IMM_B:  return {s[63:12], ins[7], ins[30:25], ins[11:8], 1'b0};
            rv_id_pkg::IMM_U:  return {s[63:32], ins[31:12], 12'h000};
            rv_id_pkg::IMM_J:  return {s[63:20], ins[19:12], ins[20], ins[30:21], 1'b0};
            rv_id_pkg::IMM_ZI: return {59'd0, ins[19:15]};
            default:           return 64'd0;
        endcase
    endfunction

    task automatic fail_timeout(input string what);
        $display("timeout in %s: %s", cur_test, what);
        $display(">>> FAIL");
        $finish;
    endtask

    // call and return on a falling edge
    task automatic send_instr(input logic [31:0] ins);
        rv_id_pkg::id_ex_t e;
        int                t;
        t = 0;
        fetch_pkt_i.pc = {$random(seed), $random(seed)} & ~64'h3;
        fetch_pkt_i.instr = ins;
        fetch_valid_i = 1'b1;
        while (!fetch_ready_o) begin
            @(negedge clk_i);
            t++;
            if (t > 200) fail_timeout("fetch_ready_o stayed low");
        end
        e.pc = fetch_pkt_i.pc;
        e.ctrl = ref_ctrl(ins);
        e.rs1_val = shadow[e.ctrl.rs1_idx];
        e.rs2_val = shadow[e.ctrl.rs2_idx];
        e.imm = ref_imm(ins, e.ctrl.imm_fmt);
        exp_q.push_back(e);
        @(negedge clk_i);
        fetch_valid_i = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [63:0] data);
        wb_req_i = '{en: 1'b1, rd: rd, data: data};
        @(negedge clk_i);
        wb_req_i.en = 1'b0;
        if (rd != 5'd0) shadow[rd] = data;
    endtask

    task automatic finish_test();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
            t++;
            if (t > 100) fail_timeout("bundles never arrived");
        end
        tests++;
        $display("test %-8s done, %0d errors", cur_test, errors - err_mark);
        err_mark = errors;
    endtask

    // every credit still owed goes back before execute stalls
    task automatic drain_credits();
        int t;
        t = 0;
        @(negedge clk_i);
        while (due_q.size() != 0) begin
            @(negedge clk_i);
            t++;
            if (t > 50) fail_timeout("credits never returned");
        end
    endtask

    // execute model, credits come back 1 to 4 cycles after each bundle
    always @(negedge clk_i) begin
        cyc++;
        ex_credit_i = 1'b0;
        if (credits_on && due_q.size() != 0 && due_q[0] <= cyc) begin
            ex_credit_i = 1'b1;
            void'(due_q.pop_front());
        end
        if (ex_valid_o) due_q.push_back(cyc + 1 + ($random(seed) & 3));
    end

    always @(negedge clk_i) begin
        if (rst_n_i && ex_valid_o) begin
            recv_cnt++;
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("%s: bundle arrived with none outstanding", cur_test);
            end
            if (exp_q.size() != 0) begin
                assert (ex_bundle_o === exp_q[0]) else begin
                    errors++;
                    $display("MISMATCH %s expected %h actual %h", cur_test, exp_q[0],
                             ex_bundle_o);
                end
                void'(exp_q.pop_front());
            end
        end
    end

    a_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (fetch_valid_i && fetch_ready_o) |=> ex_valid_o)
        else begin
            errors++;
            $display("%s: accepted word gave no bundle one cycle later", cur_test);
        end

    a_no_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ex_valid_o |-> $past(fetch_valid_i && fetch_ready_o))
        else begin
            errors++;
            $display("%s: bundle without an accepted word", cur_test);
        end

    initial begin
        logic [31:0] r;
        logic [4:0]  ops [0:6];
        int          base;
        ops = '{5'b00000, 5'b01000, 5'b11000, 5'b11011, 5'b11001, 5'b01101, 5'b00101};
        rst_n_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pkt_i = '0;
        wb_req_i = '0;
        ex_credit_i = 1'b0;
        credits_on = 1'b1;
        {cyc, errors, checks, tests, recv_cnt, err_mark} = '0;
        for (int i = 0; i < 32; i++) shadow[i] = 64'd0;
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        cur_test = "regs";
        write_reg(5'd0, 64'hdead_beef_0bad_f00d);   // x0 must stay zero
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            write_reg(r[4:0], {$random(seed), $random(seed)});
            r = $random(seed);
            send_instr({7'd0, r[24:15], 3'd0, r[11:7], 7'b0110011});
        end
        send_instr({7'd0, 5'd0, 5'd0, 3'd0, 5'd1, 7'b0110011});
        finish_test();

        cur_test = "arith";
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            send_instr({r[31:7], 1'b0, i[1], 1'b1, i[0], 3'b011});   // op, op-32, imm, imm-32
        end
        finish_test();

        cur_test = "imm";
        for (int i = 0; i < 56; i++) begin
            r = $random(seed);
            send_instr({r[31:7], ops[i % 7], 2'b11});
        end
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            send_instr({r[31:15], 1'b1, r[13:7], 7'b1110011});   // csr immediate forms
        end
        finish_test();

        cur_test = "system";
        send_instr(32'h0000_0073);    // ecall
        send_instr(32'h0010_0073);    // ebreak
        send_instr(32'h3020_0073);    // mret
        send_instr(32'h0000_100f);    // fence.i
        send_instr(32'h0000_000f);    // plain fence
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            send_instr({r[31:7], 5'b00010, 2'b11});   // custom opcode, not decoded
        end
        finish_test();

        cur_test = "flow";
        drain_credits();
        credits_on = 1'b0;
        repeat (8) @(negedge clk_i);
        base = recv_cnt;
        for (int i = 0; i < ID_CREDITS; i++) send_instr($random(seed));
        fetch_valid_i = 1'b1;
        for (int i = 0; i < 8; i++) begin
            assert (!fetch_ready_o) else begin
                errors++;
                $display("flow: fetch_ready_o high with no credits left");
            end
            @(negedge clk_i);
        end
        assert (recv_cnt - base == ID_CREDITS) else begin
            errors++;
            $display("MISMATCH flow expected %0d actual %0d", ID_CREDITS, recv_cnt - base);
        end
        credits_on = 1'b1;
        for (int i = 0; i < 80; i++) begin
            r = $random(seed);
            send_instr(r);
        end
        finish_test();

        $display("tests %0d, bundles checked %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* id_stage_top.f */
common/rv_id_pkg.sv
decode/id_decoder.sv
decode/imm_gen.sv
verilog/reg_file.sv
verilog/id_credit_pipe.sv
verilog/id_stage_top.sv
dv/id_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module id_stage_tb \
    -f id_stage_top.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vid_stage_tb > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q ">>> FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* verilog/id_credit_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module id_credit_pipe #(
    parameter int unsigned ID_CREDITS = 2
) (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       in_valid_i,
    input  rv_id_pkg::id_ex_t in_bundle_i,
    output logic            in_ready_o,
    output logic            out_valid_o,
    output rv_id_pkg::id_ex_t out_bundle_o,
    input  wire logic       credit_i
);

    localparam int unsigned CNT_W = $clog2(ID_CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(ID_CREDITS);

    logic [CNT_W-1:0] credit_cnt;
    logic             accept;

    assign in_ready_o = (credit_cnt != '0);
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_cnt <= CNT_MAX;
        end else begin
            case ({accept, credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: ; // both or neither, count holds
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= accept;    // single-cycle pulse per bundle
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) out_bundle_o <= in_bundle_i;
    end

    a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_cnt <= CNT_MAX)
        else $error("id_credit_pipe: credit count above %0d", ID_CREDITS);

    // execute returned a credit it never owed
    a_no_excess_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(credit_i && credit_cnt == CNT_MAX))
        else $error("id_credit_pipe: credit returned with full count");

    // last credit spent and none back, ready has to drop
    a_ready_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (accept && !credit_i && credit_cnt == CNT_W'(1)) |=> !in_ready_o)
        else $error("id_credit_pipe: ready with no credit");

endmodule

`default_nettype wire

/* verilog/id_stage_top.sv */
`timescale 1ns/10ps
`default_nettype none

module id_stage_top #(
    parameter int unsigned ID_CREDITS = 2
) (
    input  wire logic          clk_i,
    input  wire logic          rst_n_i,
    input  wire logic          fetch_valid_i,
    input  rv_id_pkg::fetch_pkt_t fetch_pkt_i,
    output logic               fetch_ready_o,
    input  rv_id_pkg::wb_req_t wb_req_i,
    output logic               ex_valid_o,
    output rv_id_pkg::id_ex_t  ex_bundle_o,
    input  wire logic          ex_credit_i
);

    rv_id_pkg::id_ctrl_t        ctrl;
    rv_id_pkg::id_ex_t          id_bundle;
    logic [rv_id_pkg::XLEN-1:0] imm;
    logic [rv_id_pkg::XLEN-1:0] rs1_val;
    logic [rv_id_pkg::XLEN-1:0] rs2_val;

    id_decoder u_id_decoder (
        .instr_i (fetch_pkt_i.instr),
        .ctrl_o  (ctrl)
    );

    imm_gen u_imm_gen (
        .instr_i (fetch_pkt_i.instr),
        .fmt_i   (ctrl.imm_fmt),
        .imm_o   (imm)
    );

    reg_file u_reg_file (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rs1_idx_i (ctrl.rs1_idx),
        .rs2_idx_i (ctrl.rs2_idx),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val),
        .wb_req_i  (wb_req_i)
    );

    assign id_bundle = '{pc: fetch_pkt_i.pc, ctrl: ctrl, rs1_val: rs1_val,
                         rs2_val: rs2_val, imm: imm};

    id_credit_pipe #(
        .ID_CREDITS (ID_CREDITS)
    ) u_id_credit_pipe (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (fetch_valid_i),
        .in_bundle_i  (id_bundle),
        .in_ready_o   (fetch_ready_o),
        .out_valid_o  (ex_valid_o),
        .out_bundle_o (ex_bundle_o),
        .credit_i     (ex_credit_i)
    );

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic                            clk_i,
    input  wire logic                            rst_n_i,
    input  wire logic [rv_id_pkg::REG_IDX_W-1:0] rs1_idx_i,
    input  wire logic [rv_id_pkg::REG_IDX_W-1:0] rs2_idx_i,
    output logic      [rv_id_pkg::XLEN-1:0]      rs1_val_o,
    output logic      [rv_id_pkg::XLEN-1:0]      rs2_val_o,
    input  rv_id_pkg::wb_req_t                   wb_req_i
);

    logic [rv_id_pkg::XLEN-1:0] regs [1:31];   // x0 has no storage
    logic                       wr_en;

    assign wr_en = wb_req_i.en && (wb_req_i.rd != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_req_i.rd] <= wb_req_i.data;
        end
    end

    // no bypass, a same-cycle write shows up next cycle
    assign rs1_val_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_val_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

`default_nettype wire
